/* logic/main_bus_pkg.sv */
// Main CPU bus package with region encoding, bus widths and the address map
package main_bus_pkg;

    localparam int ADDR_W = 23;
    localparam int DATA_W = 16;

    // Regions seen by the main CPU
    typedef enum logic [2:0] {
        REG_NONE   = 3'd0,
        REG_ROM    = 3'd1,
        REG_RAM    = 3'd2,
        REG_VRAM   = 3'd3,
        REG_ORAM   = 3'd4,
        REG_IO     = 3'd5,
        REG_QSND   = 3'd6,
        REG_OBJCFG = 3'd7
    } region_e;

    // Address map, first match wins
    function automatic region_e decode_region(
        input logic [ADDR_W:1] a,
        input logic            rnw,
        input logic [3:0]      oram_page
    );
        if (a[23:22] == 2'b00)
            return REG_ROM;
        if (&a[23:16])
            return REG_RAM;
        if (a[23:18] == 6'b100100 && a[17:16] != 2'b11)
            return REG_VRAM;
        if (a[23:20] == 4'h7 && a[19:16] == oram_page)
            return REG_ORAM;
        if (a[23:19] == 5'b10000)
            return REG_IO;
        // Sound CPU window, 60_0000 to 61_FFFF
        if (a[23:20] == 4'h6 && a[19:17] == 3'd0)
            return REG_QSND;
        // Object config sits at 40_0000 with decryption on
        if (a[23:20] == 4'h4 && !rnw)
            return REG_OBJCFG;
        return REG_NONE;
    endfunction

    // RAM, VRAM and object RAM share the same external memory
    function automatic logic region_is_ram(input region_e r);
        return r == REG_RAM || r == REG_VRAM || r == REG_ORAM;
    endfunction

endpackage

/* logic/main_io_pkg.sv */
// I/O page package with register offsets, joystick modes and port constants
package main_io_pkg;

    // Word offset on address bits 8:3
    typedef enum logic [5:0] {
        IO_IN0   = 6'h00,
        IO_IN1   = 6'h02,
        IO_IN2   = 6'h04,
        IO_VOL   = 6'h06,
        IO_OUT   = 6'h08,
        IO_OBANK = 6'h1C
    } io_reg_e;

    // Any value other than JOY_SIX means four buttons
    typedef enum logic [1:0] {
        JOY_SIX  = 2'd0,
        JOY_FOUR = 2'd1
    } joy_mode_e;

    // Video chip selects on address bits 8:6
    localparam logic [2:0] PPU1_SEL = 3'b100;
    localparam logic [2:0] PPU2_SEL = 3'b101;

    // Fill bits in the input words
    localparam logic [4:0] IN2_PAD = 5'b11111;
    localparam logic [2:0] VOL_PAD = 3'b111;

    // Bit positions in the output latch words
    localparam int OUT_Z80_BIT  = 3;
    localparam int EE_SDI_BIT   = 12;
    localparam int EE_SCLK_BIT  = 13;
    localparam int EE_SCS_BIT   = 14;
    localparam int OBANK_BIT    = 0;

endpackage

/* logic/region_bus_if.sv */
// Latched bus cycle passed from the region decoder to its targets
interface region_bus_if;

    // A strobed cycle is in progress
    logic                              cyc;
    main_bus_pkg::region_e             region;
    logic [main_bus_pkg::ADDR_W:1]     addr;
    logic                              rnw;
    // Byte lanes, active high
    logic                              uds;
    logic                              lds;
    logic [main_bus_pkg::DATA_W-1:0]   wdata;

    modport decoder (
        output cyc,
        output region,
        output addr,
        output rnw,
        output uds,
        output lds,
        output wdata
    );

    modport target (
        input  cyc,
        input  region,
        input  addr,
        input  rnw,
        input  uds,
        input  lds,
        input  wdata
    );

endinterface

/* logic/region_decode.sv */
// Region decoder latching each strobed cycle and driving the memory selects
module region_decode (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              addr_strobe,
    input  logic [main_bus_pkg::ADDR_W:1]     addr,
    input  logic                              rnw,
    input  logic                              uds,
    input  logic                              lds,
    input  logic [main_bus_pkg::DATA_W-1:0]   cpu_dout,
    input  logic [15:0]                       oram_base,
    output logic                              rom_cs,
    output logic [21:1]                       rom_addr,
    output logic                              ram_cs,
    output logic                              vram_cs,
    output logic                              oram_cs,
    output logic [17:1]                       mem_addr,
    output logic                              qs_cs,
    output logic [23:1]                       qs_addr,
    region_bus_if.decoder                     bus
);

    logic [main_bus_pkg::ADDR_W:1]    addr_q;
    logic                             rnw_q;
    logic                             uds_q;
    logic                             lds_q;
    logic [main_bus_pkg::DATA_W-1:0]  wdata_q;
    main_bus_pkg::region_e            region_d;
    main_bus_pkg::region_e            region_q;
    logic                             cyc_q;

    always_comb begin
        region_d = main_bus_pkg::decode_region(addr, rnw, oram_base[11:8]);
    end

    // Cycle payload, held stable by the master while the strobe is up
    always_ff @(posedge clk) begin
        if (addr_strobe) begin
            addr_q  <= addr;
            rnw_q   <= rnw;
            uds_q   <= uds;
            lds_q   <= lds;
            wdata_q <= cpu_dout;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cyc_q    <= 1'b0;
            region_q <= main_bus_pkg::REG_NONE;
            rom_cs   <= 1'b0;
            ram_cs   <= 1'b0;
            vram_cs  <= 1'b0;
            oram_cs  <= 1'b0;
            qs_cs    <= 1'b0;
        end else if (addr_strobe) begin
            cyc_q    <= 1'b1;
            region_q <= region_d;
            rom_cs   <= region_d == main_bus_pkg::REG_ROM;
            ram_cs   <= region_d == main_bus_pkg::REG_RAM;
            vram_cs  <= region_d == main_bus_pkg::REG_VRAM;
            oram_cs  <= region_d == main_bus_pkg::REG_ORAM;
            qs_cs    <= region_d == main_bus_pkg::REG_QSND;
        end else begin
            cyc_q    <= 1'b0;
            region_q <= main_bus_pkg::REG_NONE;
            rom_cs   <= 1'b0;
            ram_cs   <= 1'b0;
            vram_cs  <= 1'b0;
            oram_cs  <= 1'b0;
            qs_cs    <= 1'b0;
        end
    end

    // RAM and VRAM sit next to each other in the shared memory
    assign mem_addr = ram_cs ? {2'b00, addr_q[15:1]} : addr_q[17:1];
    assign rom_addr = addr_q[21:1];
    assign qs_addr  = addr_q;

    assign bus.cyc    = cyc_q;
    assign bus.region = region_q;
    assign bus.addr   = addr_q;
    assign bus.rnw    = rnw_q;
    assign bus.uds    = uds_q;
    assign bus.lds    = lds_q;
    assign bus.wdata  = wdata_q;

endmodule

/* logic/io_registers.sv */
// I/O page sub-decoder with input ports, output latches and object RAM base
module io_registers (
    input  logic                     clk,
    input  logic                     rst,
    region_bus_if.target             bus,
    input  main_io_pkg::joy_mode_e   joymode,
    input  logic [9:0]               joystick1,
    input  logic [9:0]               joystick2,
    input  logic [9:0]               joystick3,
    input  logic [9:0]               joystick4,
    input  logic [3:0]               start_button,
    input  logic [3:0]               coin_input,
    input  logic                     service,
    input  logic                     dip_test,
    input  logic                     eeprom_sdo,
    input  logic [12:0]              volume,
    output logic                     ppu1_cs,
    output logic                     ppu2_cs,
    output logic [15:0]              io_rdata,
    output logic                     eeprom_sclk,
    output logic                     eeprom_sdi,
    output logic                     eeprom_scs,
    output logic                     z80_rstn,
    output logic                     obank,
    output logic [15:0]              oram_base
);

    main_io_pkg::io_reg_e  offset;
    logic                  io_sel;
    logic                  io_wr;
    logic                  cfg_wr;
    logic [15:0]           in0_d;
    logic [15:0]           in1_d;
    logic [15:0]           in2_d;
    logic [15:0]           in0_q;
    logic [15:0]           in1_q;
    logic [15:0]           in2_q;

    assign offset = main_io_pkg::io_reg_e'(bus.addr[8:3]);
    assign io_sel = bus.cyc && bus.region == main_bus_pkg::REG_IO;
    assign io_wr  = io_sel && !bus.rnw;
    // Only word 0 of the config block holds the base
    assign cfg_wr = bus.cyc && bus.region == main_bus_pkg::REG_OBJCFG && bus.addr[3:1] == 3'd0;

    assign ppu1_cs = io_sel && bus.addr[8:6] == main_io_pkg::PPU1_SEL;
    assign ppu2_cs = io_sel && bus.addr[8:6] == main_io_pkg::PPU2_SEL;

    // Four-button layout first, six-button mode patches it
    always_comb begin
        in0_d = {joystick2[7:0], joystick1[7:0]};
        in1_d = {joystick4[7:0], joystick3[7:0]};
        in2_d = {coin_input, start_button, main_io_pkg::IN2_PAD, service, dip_test, eeprom_sdo};
        if (joymode == main_io_pkg::JOY_SIX) begin
            in0_d[15]  = 1'b1;
            in0_d[7]   = 1'b1;
            in1_d      = 16'hFFFF;
            in1_d[2:0] = joystick1[9:7];
            in1_d[5:4] = joystick2[8:7];
            in2_d[14]  = joystick2[9];
        end
    end

    always_ff @(posedge clk) begin
        in0_q <= in0_d;
        in1_q <= in1_d;
        in2_q <= in2_d;
    end

    always_comb begin
        io_rdata = 16'hFFFF;
        if (io_sel) begin
            case (offset)
                main_io_pkg::IO_IN0: io_rdata = in0_q;
                main_io_pkg::IO_IN1: io_rdata = in1_q;
                main_io_pkg::IO_IN2: io_rdata = in2_q;
                main_io_pkg::IO_VOL: io_rdata = {main_io_pkg::VOL_PAD, volume};
                default: io_rdata = 16'hFFFF;
            endcase
        end
    end

    // Latches reload every edge of the write, same value each time
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            eeprom_sclk <= 1'b0;
            eeprom_sdi  <= 1'b0;
            eeprom_scs  <= 1'b0;
            z80_rstn    <= 1'b0;
            obank       <= 1'b0;
            oram_base   <= 16'h0000;
        end else begin
            if (io_wr && offset == main_io_pkg::IO_OUT && bus.lds)
                z80_rstn <= bus.wdata[main_io_pkg::OUT_Z80_BIT];
            // EEPROM bit-bang on the upper lane
            if (io_wr && offset == main_io_pkg::IO_OUT && bus.uds) begin
                eeprom_sdi  <= bus.wdata[main_io_pkg::EE_SDI_BIT];
                eeprom_sclk <= bus.wdata[main_io_pkg::EE_SCLK_BIT];
                eeprom_scs  <= bus.wdata[main_io_pkg::EE_SCS_BIT];
            end
            if (io_wr && offset == main_io_pkg::IO_OBANK && bus.lds)
                obank <= bus.wdata[main_io_pkg::OBANK_BIT];
            if (cfg_wr && bus.uds)
                oram_base[15:8] <= bus.wdata[15:8];
            if (cfg_wr && bus.lds)
                oram_base[7:0] <= bus.wdata[7:0];
        end
    end

endmodule

/* logic/bus_response.sv */
// Read data mux and dtack generation with wait states per region
module bus_response #(
    parameter int IO_WAIT = 1
) (
    input  logic          clk,
    input  logic          rst,
    region_bus_if.target  bus,
    input  logic [15:0]   io_rdata,
    input  logic [15:0]   rom_data,
    input  logic [15:0]   ram_data,
    input  logic [7:0]    qs_din,
    input  logic [15:0]   mmr_dout,
    input  logic          ppu2_cs,
    input  logic          rom_ok,
    input  logic          ram_ok,
    input  logic          qs_ok,
    output logic [15:0]   cpu_din,
    output logic          dtack
);

    localparam int CNT_W = (IO_WAIT > 0) ? $clog2(IO_WAIT + 1) : 1;

    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        ACK
    } state_e;

    state_e              state;
    logic [CNT_W-1:0]    wait_cnt;
    logic                ready;
    logic [15:0]         rdata;

    // Memories answer with their ok, internal regions count down
    always_comb begin
        if (bus.region == main_bus_pkg::REG_ROM)
            ready = rom_ok;
        else if (main_bus_pkg::region_is_ram(bus.region))
            ready = ram_ok;
        else if (bus.region == main_bus_pkg::REG_QSND)
            ready = qs_ok;
        else
            ready = wait_cnt == '0;
    end

    always_comb begin
        if (ppu2_cs)
            rdata = mmr_dout;
        else if (bus.region == main_bus_pkg::REG_QSND)
            rdata = {8'hFF, qs_din};
        else if (bus.region == main_bus_pkg::REG_ROM)
            rdata = rom_data;
        else if (main_bus_pkg::region_is_ram(bus.region))
            rdata = ram_data;
        else
            rdata = io_rdata;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            wait_cnt <= CNT_W'(IO_WAIT);
            cpu_din  <= 16'hFFFF;
        end else begin
            case (state)
                IDLE, WAIT: begin
                    if (!bus.cyc) begin
                        state    <= IDLE;
                        wait_cnt <= CNT_W'(IO_WAIT);
                    end else if (ready) begin
                        state   <= ACK;
                        cpu_din <= rdata;
                    end else begin
                        state <= WAIT;
                        if (wait_cnt != '0)
                            wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                ACK: begin
                    if (!bus.cyc) begin
                        state    <= IDLE;
                        wait_cnt <= CNT_W'(IO_WAIT);
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Drops together with the selects once the strobe goes away
    assign dtack = state == ACK && bus.cyc;

endmodule

/* logic/main_bus.sv */
// Main CPU bus glue top level with region decode, I/O page and bus response
module main_bus #(
    parameter int IO_WAIT = 1
) (
    input  logic          clk,
    input  logic          rst,
    // CPU bus
    input  logic          addr_strobe,
    input  logic [23:1]   addr,
    input  logic          rnw,
    input  logic          uds,
    input  logic          lds,
    input  logic [15:0]   cpu_dout,
    output logic [15:0]   cpu_din,
    output logic          dtack,
    // ROM
    output logic          rom_cs,
    output logic [21:1]   rom_addr,
    input  logic [15:0]   rom_data,
    input  logic          rom_ok,
    // Shared RAM, VRAM and object RAM
    output logic          ram_cs,
    output logic          vram_cs,
    output logic          oram_cs,
    output logic [17:1]   mem_addr,
    input  logic [15:0]   ram_data,
    input  logic          ram_ok,
    output logic          obank,
    output logic [15:0]   oram_base,
    // Sound CPU window
    output logic          qs_cs,
    output logic [23:1]   qs_addr,
    input  logic [7:0]    qs_din,
    input  logic          qs_ok,
    output logic          z80_rstn,
    input  logic [12:0]   volume,
    // Video chips
    output logic          ppu1_cs,
    output logic          ppu2_cs,
    input  logic [15:0]   mmr_dout,
    // Cabinet
    input  logic [1:0]    joymode,
    input  logic [9:0]    joystick1,
    input  logic [9:0]    joystick2,
    input  logic [9:0]    joystick3,
    input  logic [9:0]    joystick4,
    input  logic [3:0]    start_button,
    input  logic [3:0]    coin_input,
    input  logic          service,
    input  logic          dip_test,
    // EEPROM
    output logic          eeprom_sclk,
    output logic          eeprom_sdi,
    output logic          eeprom_scs,
    input  logic          eeprom_sdo
);

    logic [15:0]  io_rdata;

    region_bus_if bus_if ();

    region_decode region_decode_inst (
        .clk         (clk),
        .rst         (rst),
        .addr_strobe (addr_strobe),
        .addr        (addr),
        .rnw         (rnw),
        .uds         (uds),
        .lds         (lds),
        .cpu_dout    (cpu_dout),
        .oram_base   (oram_base),
        .rom_cs      (rom_cs),
        .rom_addr    (rom_addr),
        .ram_cs      (ram_cs),
        .vram_cs     (vram_cs),
        .oram_cs     (oram_cs),
        .mem_addr    (mem_addr),
        .qs_cs       (qs_cs),
        .qs_addr     (qs_addr),
        .bus         (bus_if.decoder)
    );

    io_registers io_registers_inst (
        .clk          (clk),
        .rst          (rst),
        .bus          (bus_if.target),
        .joymode      (main_io_pkg::joy_mode_e'(joymode)),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .joystick3    (joystick3),
        .joystick4    (joystick4),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .dip_test     (dip_test),
        .eeprom_sdo   (eeprom_sdo),
        .volume       (volume),
        .ppu1_cs      (ppu1_cs),
        .ppu2_cs      (ppu2_cs),
        .io_rdata     (io_rdata),
        .eeprom_sclk  (eeprom_sclk),
        .eeprom_sdi   (eeprom_sdi),
        .eeprom_scs   (eeprom_scs),
        .z80_rstn     (z80_rstn),
        .obank        (obank),
        .oram_base    (oram_base)
    );

    bus_response #(
        .IO_WAIT (IO_WAIT)
    ) bus_response_inst (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus_if.target),
        .io_rdata (io_rdata),
        .rom_data (rom_data),
        .ram_data (ram_data),
        .qs_din   (qs_din),
        .mmr_dout (mmr_dout),
        .ppu2_cs  (ppu2_cs),
        .rom_ok   (rom_ok),
        .ram_ok   (ram_ok),
        .qs_ok    (qs_ok),
        .cpu_din  (cpu_din),
        .dtack    (dtack)
    );

endmodule

/* sim/main_bus_tb.sv */
// Testbench for the main CPU bus glue with a bus master, memory responders and a reference model
module main_bus_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int IO_WAIT     = 2;
    localparam int CLK_PERIOD  = 8;
    localparam int DTACK_LIMIT = 32;

    // Transactions per test, the watchdog scales with the sum
    localparam int MEM_TX   = 32;
    localparam int PORT_TX  = 32;
    localparam int LATCH_TX = 12;
    localparam int OBJ_TX   = 10;
    localparam int INT_TX   = 10;
    localparam int N_TX     = MEM_TX + PORT_TX + LATCH_TX + OBJ_TX + INT_TX;

    // Byte addresses on the I/O page
    localparam logic [23:0] IN0_ADDR   = 24'h80_0000;
    localparam logic [23:0] IN1_ADDR   = 24'h80_0010;
    localparam logic [23:0] IN2_ADDR   = 24'h80_0020;
    localparam logic [23:0] VOL_ADDR   = 24'h80_0030;
    localparam logic [23:0] OUT_ADDR   = 24'h80_0040;
    localparam logic [23:0] OBANK_ADDR = 24'h80_00E0;
    localparam logic [23:0] PPU1_ADDR  = 24'h80_0100;
    localparam logic [23:0] PPU2_ADDR  = 24'h80_0140;
    localparam logic [23:0] CFG_ADDR   = 24'h40_0000;

    logic          clk;
    logic          rst;
    logic          addr_strobe;
    logic [23:1]   addr;
    logic          rnw;
    logic          uds;
    logic          lds;
    logic [15:0]   cpu_dout;
    logic [15:0]   cpu_din;
    logic          dtack;
    logic          rom_cs;
    logic [21:1]   rom_addr;
    logic [15:0]   rom_data = 16'h0000;
    logic          rom_ok = 1'b0;
    logic          ram_cs;
    logic          vram_cs;
    logic          oram_cs;
    logic [17:1]   mem_addr;
    logic [15:0]   ram_data = 16'h0000;
    logic          ram_ok = 1'b0;
    logic          obank;
    logic [15:0]   oram_base;
    logic          qs_cs;
    logic [23:1]   qs_addr;
    logic [7:0]    qs_din = 8'h00;
    logic          qs_ok = 1'b0;
    logic          z80_rstn;
    logic [12:0]   volume;
    logic          ppu1_cs;
    logic          ppu2_cs;
    logic [15:0]   mmr_dout;
    logic [1:0]    joymode;
    logic [9:0]    joystick1;
    logic [9:0]    joystick2;
    logic [9:0]    joystick3;
    logic [9:0]    joystick4;
    logic [3:0]    start_button;
    logic [3:0]    coin_input;
    logic          service;
    logic          dip_test;
    logic          eeprom_sclk;
    logic          eeprom_sdi;
    logic          eeprom_scs;
    logic          eeprom_sdo;

    // Random state and responder delay
    logic [31:0]   lfsr = 32'h7ad0_2761;
    logic [2:0]    ok_delay = 3'd0;
    logic [2:0]    wait_left = 3'd0;

    // Model copies of the latches
    logic          m_z80 = 1'b0;
    logic          m_sdi = 1'b0;
    logic          m_sclk = 1'b0;
    logic          m_scs = 1'b0;
    logic          m_obank = 1'b0;
    logic [15:0]   m_base = 16'h0000;

    // Last completed read, handed to the compare process
    logic [23:0]   rd_addr;
    logic [15:0]   rd_data;
    event          read_done;

    main_bus #(
        .IO_WAIT (IO_WAIT)
    ) main_bus_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Galois LFSR, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr[0];
            lfsr = lfsr >> 1;
            if (b)
                lfsr = lfsr ^ 32'h8020_0003;
            v = {v[30:0], b};
        end
        return v;
    endfunction

    function automatic logic [23:0] rand_addr(input logic [23:0] mask, input logic [23:0] fixed);
        return (24'(rand_bits(24)) & mask) | fixed;
    endfunction

    // Memory fill, every address bit reaches the word
    function automatic logic [15:0] mem_word(input logic [23:1] a);
        return a[16:1] ^ {a[23:17], a[23:17], 2'b10};
    endfunction

    function automatic logic [7:0] qs_byte(input logic [23:1] a);
        return a[8:1] ^ a[16:9] ^ {1'b0, a[23:17]};
    endfunction

    // Address map on the byte address, first match wins
    function automatic main_bus_pkg::region_e classify(input logic [23:0] ba, input logic wr);
        main_bus_pkg::region_e r;
        if (ba[23:22] == 2'b00)
            r = main_bus_pkg::REG_ROM;
        else if (ba[23:16] == 8'hFF)
            r = main_bus_pkg::REG_RAM;
        else if (ba[23:18] == 6'b100100 && ba[17:16] != 2'b11)
            r = main_bus_pkg::REG_VRAM;
        else if (ba[23:20] == 4'h7 && ba[19:16] == m_base[11:8])
            r = main_bus_pkg::REG_ORAM;
        else if (ba[23:19] == 5'b10000)
            r = main_bus_pkg::REG_IO;
        else if (ba[23:20] == 4'h6 && ba[19:17] == 3'b000)
            r = main_bus_pkg::REG_QSND;
        else if (ba[23:20] == 4'h4 && wr)
            r = main_bus_pkg::REG_OBJCFG;
        else
            r = main_bus_pkg::REG_NONE;
        return r;
    endfunction

    function automatic logic is_memory(input main_bus_pkg::region_e r);
        return r inside {main_bus_pkg::REG_ROM, main_bus_pkg::REG_RAM, main_bus_pkg::REG_VRAM,
                         main_bus_pkg::REG_ORAM, main_bus_pkg::REG_QSND};
    endfunction

    // Input port words from the cabinet inputs
    function automatic logic [15:0] port_word(input logic [5:0] off);
        logic six;
        six = joymode == 2'd0;
        case (off)
            6'h00: return six ? {1'b1, joystick2[6:0], 1'b1, joystick1[6:0]}
                              : {joystick2[7:0], joystick1[7:0]};
            6'h02: return six ? {10'h3FF, joystick2[8:7], 1'b1, joystick1[9:7]}
                              : {joystick4[7:0], joystick3[7:0]};
            6'h04: return {coin_input[3], six ? joystick2[9] : coin_input[2], coin_input[1:0],
                           start_button, 5'h1F, service, dip_test, eeprom_sdo};
            6'h06: return {3'b111, volume};
            default: return 16'hFFFF;
        endcase
    endfunction

    function automatic logic [15:0] expect_read(input logic [23:0] ba);
        case (classify(ba, 1'b0))
            main_bus_pkg::REG_ROM: return mem_word({2'b00, ba[21:1]});
            main_bus_pkg::REG_RAM: return mem_word({8'h00, ba[15:1]});
            main_bus_pkg::REG_VRAM, main_bus_pkg::REG_ORAM: return mem_word({6'h00, ba[17:1]});
            main_bus_pkg::REG_QSND: return {8'hFF, qs_byte(ba[23:1])};
            main_bus_pkg::REG_IO: return (ba[8:6] == 3'b101) ? mmr_dout : port_word(ba[8:3]);
            default: return 16'hFFFF;
        endcase
    endfunction

    task automatic expect_equal(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("** FAIL **");
            $fatal(1, "mismatch in %s", what);
        end
    endtask

    task automatic abort_run(input string why);
        $display("Error: %s", why);
        $display("** FAIL **");
        $fatal(1, "run aborted");
    endtask

    // ROM, RAM and sound window answer ok_delay cycles after their select
    always @(negedge clk) begin
        if (rom_cs || ram_cs || vram_cs || oram_cs || qs_cs) begin
            if (wait_left == 3'd0) begin
                rom_ok   <= rom_cs;
                ram_ok   <= ram_cs || vram_cs || oram_cs;
                qs_ok    <= qs_cs;
                rom_data <= mem_word({2'b00, rom_addr});
                ram_data <= mem_word({6'h00, mem_addr});
                qs_din   <= qs_byte(qs_addr);
            end else begin
                wait_left <= wait_left - 3'd1;
            end
        end else begin
            rom_ok    <= 1'b0;
            ram_ok    <= 1'b0;
            qs_ok     <= 1'b0;
            wait_left <= ok_delay;
        end
    end

    always @(read_done)
        expect_equal($sformatf("read data at %h", rd_addr), rd_data, expect_read(rd_addr));

    task automatic verify_selects(input logic [23:0] ba, input main_bus_pkg::region_e r);
        expect_equal("rom_cs", rom_cs, r == main_bus_pkg::REG_ROM);
        expect_equal("ram_cs", ram_cs, r == main_bus_pkg::REG_RAM);
        expect_equal("vram_cs", vram_cs, r == main_bus_pkg::REG_VRAM);
        expect_equal("oram_cs", oram_cs, r == main_bus_pkg::REG_ORAM);
        expect_equal("qs_cs", qs_cs, r == main_bus_pkg::REG_QSND);
        expect_equal("ppu1_cs", ppu1_cs, r == main_bus_pkg::REG_IO && ba[8:6] == 3'b100);
        expect_equal("ppu2_cs", ppu2_cs, r == main_bus_pkg::REG_IO && ba[8:6] == 3'b101);
        if (r == main_bus_pkg::REG_ROM)
            expect_equal("rom_addr", rom_addr, ba[21:1]);
        if (r == main_bus_pkg::REG_RAM)
            expect_equal("mem_addr", mem_addr, {2'b00, ba[15:1]});
        if (r == main_bus_pkg::REG_VRAM || r == main_bus_pkg::REG_ORAM)
            expect_equal("mem_addr", mem_addr, ba[17:1]);
        if (r == main_bus_pkg::REG_QSND)
            expect_equal("qs_addr", qs_addr, ba[23:1]);
    endtask

    task automatic compare_latches();
        expect_equal("z80_rstn", z80_rstn, m_z80);
        expect_equal("eeprom_sdi", eeprom_sdi, m_sdi);
        expect_equal("eeprom_sclk", eeprom_sclk, m_sclk);
        expect_equal("eeprom_scs", eeprom_scs, m_scs);
        expect_equal("obank", obank, m_obank);
        expect_equal("oram_base", oram_base, m_base);
    endtask

    // One strobe/dtack cycle, edges counted from the strobe
    task automatic bus_cycle(input logic [23:0] ba, input logic is_read, input logic u,
                             input logic l, input logic [15:0] wd);
        main_bus_pkg::region_e r;
        int edge_n;
        int want;
        r = classify(ba, !is_read);
        ok_delay = 3'(rand_bits(3));
        want = is_memory(r) ? 2 + int'(ok_delay) : 2 + IO_WAIT;
        @(negedge clk);
        addr_strobe = 1'b1;
        addr = ba[23:1];
        rnw = is_read;
        uds = u;
        lds = l;
        cpu_dout = wd;
        edge_n = 0;
        do begin
            @(negedge clk);
            edge_n++;
            if (edge_n == 1)
                verify_selects(ba, r);
            if (edge_n > DTACK_LIMIT)
                abort_run($sformatf("dtack never came for address %h", ba));
        end while (!dtack);
        expect_equal($sformatf("dtack edge at %h", ba), edge_n, want);
        if (is_read) begin
            rd_addr = ba;
            rd_data = cpu_din;
            -> read_done;
        end
        addr_strobe = 1'b0;
        @(negedge clk);
        expect_equal("dtack after strobe", dtack, 1'b0);
        expect_equal("selects after strobe",
                     {rom_cs, ram_cs, vram_cs, oram_cs, qs_cs, ppu1_cs, ppu2_cs}, 7'd0);
    endtask

    task automatic do_read(input logic [23:0] ba);
        bus_cycle(ba, 1'b1, 1'b1, 1'b1, 16'h0000);
    endtask

    task automatic apply_write(input logic [23:0] ba, input logic u, input logic l,
                               input logic [15:0] wd);
        main_bus_pkg::region_e r;
        r = classify(ba, 1'b1);
        if (r == main_bus_pkg::REG_IO && ba[8:3] == 6'h08 && l)
            m_z80 = wd[3];
        if (r == main_bus_pkg::REG_IO && ba[8:3] == 6'h08 && u) begin
            m_sdi  = wd[12];
            m_sclk = wd[13];
            m_scs  = wd[14];
        end
        if (r == main_bus_pkg::REG_IO && ba[8:3] == 6'h1C && l)
            m_obank = wd[0];
        if (r == main_bus_pkg::REG_OBJCFG && ba[3:1] == 3'd0 && u)
            m_base[15:8] = wd[15:8];
        if (r == main_bus_pkg::REG_OBJCFG && ba[3:1] == 3'd0 && l)
            m_base[7:0] = wd[7:0];
    endtask

    task automatic do_write(input logic [23:0] ba, input logic u, input logic l,
                            input logic [15:0] wd);
        bus_cycle(ba, 1'b0, u, l, wd);
        apply_write(ba, u, l, wd);
        compare_latches();
    endtask

    task automatic randomize_inputs(input logic [1:0] mode);
        joymode      = mode;
        joystick1    = 10'(rand_bits(10));
        joystick2    = 10'(rand_bits(10));
        joystick3    = 10'(rand_bits(10));
        joystick4    = 10'(rand_bits(10));
        start_button = 4'(rand_bits(4));
        coin_input   = 4'(rand_bits(4));
        service      = 1'(rand_bits(1));
        dip_test     = 1'(rand_bits(1));
        eeprom_sdo   = 1'(rand_bits(1));
        volume       = 13'(rand_bits(13));
    endtask

    initial begin
        #(CLK_PERIOD * 200 * N_TX);
        abort_run("watchdog expired before all transactions finished");
    end

    initial begin
        logic [23:0] va;
        rst = 1'b1;
        addr_strobe = 1'b0;
        addr = '0;
        rnw = 1'b1;
        uds = 1'b0;
        lds = 1'b0;
        cpu_dout = 16'h0000;
        mmr_dout = 16'h0000;
        randomize_inputs(2'd1);
        repeat (3) @(negedge clk);
        rst = 1'b0;

        // Reset values
        expect_equal("dtack at reset", dtack, 1'b0);
        expect_equal("selects at reset",
                     {rom_cs, ram_cs, vram_cs, oram_cs, qs_cs, ppu1_cs, ppu2_cs}, 7'd0);
        expect_equal("cyc at reset", main_bus_inst.bus_if.cyc, 1'b0);
        expect_equal("cpu_din at reset", cpu_din, 16'hFFFF);
        compare_latches();

        // Memory regions under random ok delays
        for (int i = 0; i < MEM_TX / 4; i++) begin
            do_read(rand_addr(24'h3F_FFFE, 24'h00_0000));
            do_read(rand_addr(24'h00_FFFE, 24'hFF_0000));
            va = rand_addr(24'h03_FFFE, 24'h90_0000);
            if (va[17:16] == 2'b11)
                va[17] = 1'b0;
            do_read(va);
            do_read(rand_addr(24'h01_FFFE, 24'h60_0000));
        end

        // Input ports in every joymode value
        for (int mode = 0; mode < 4; mode++) begin
            repeat (PORT_TX / 16) begin
                randomize_inputs(2'(mode));
                do_read(IN0_ADDR);
                do_read(IN1_ADDR);
                do_read(IN2_ADDR);
                do_read(VOL_ADDR);
            end
        end

        // Output latches, each lane pattern on both registers
        for (int i = 0; i < LATCH_TX; i++)
            do_write(((i / 3) % 2 == 1) ? OBANK_ADDR : OUT_ADDR, (i % 3) != 0, (i % 3) != 1,
                     16'(rand_bits(16)));

        // Object RAM window follows the base register
        repeat (OBJ_TX / 5) begin
            do_write(CFG_ADDR, 1'b0, 1'b1, 16'(rand_bits(16)));
            do_write(CFG_ADDR, 1'b1, 1'b0, 16'(rand_bits(16)));
            do_read(rand_addr(24'h00_FFFE, {4'h7, m_base[11:8], 16'h0000}));
            do_read(rand_addr(24'h00_FFFE, {4'h7, m_base[11:8] + 4'h1, 16'h0000}));
            do_read(rand_addr(24'h00_FFFE, {4'h7, m_base[11:8], 16'h0000}));
        end

        // Internal regions and unmapped space
        mmr_dout = 16'(rand_bits(16));
        do_read(PPU1_ADDR);
        do_read(PPU2_ADDR);
        do_read(24'h80_0178);
        do_read(OUT_ADDR);
        do_read(CFG_ADDR);
        do_read(rand_addr(24'h0F_FFFE, 24'h50_0000));
        do_read(rand_addr(24'h0F_FFFE, 24'hA0_0000));
        do_read(rand_addr(24'h07_FFFE, 24'h88_0000));
        do_write(24'h62_0000, 1'b1, 1'b1, 16'(rand_bits(16)));
        do_write(PPU1_ADDR, 1'b1, 1'b1, 16'(rand_bits(16)));

        $display("** PASS **");
        $finish;
    end

endmodule

/* build.f */
logic/main_bus_pkg.sv
logic/main_io_pkg.sv
logic/region_bus_if.sv
logic/region_decode.sv
logic/io_registers.sv
logic/bus_response.sv
logic/main_bus.sv
sim/main_bus_tb.sv

/* Bender.yml */
package:
  name: main_bus

sources:
  - files:
      - logic/main_bus_pkg.sv
      - logic/main_io_pkg.sv
      - logic/region_bus_if.sv
      - logic/region_decode.sv
      - logic/io_registers.sv
      - logic/bus_response.sv
      - logic/main_bus.sv
  - target: simulation
    files:
      - sim/main_bus_tb.sv
